// ==== hdl/bft_pkg.sv ====
package bft_pkg;

    // Tree packet geometry.
    localparam int PACKET_BITS  = 49;
    localparam int PAYLOAD_BITS = 32;
    localparam int LEAF_BITS    = 5;
    localparam int PORT_BITS    = 4;
    localparam int ADDR_BITS    = 7;

    // User data word on every kernel stream.
    typedef logic [PAYLOAD_BITS-1:0] user_word_t;

    // Header fields first, payload in the low bits.
    typedef struct packed {
        logic                  vld;      // Real packet.
        logic [LEAF_BITS-1:0]  leaf;     // Destination leaf.
        logic [PORT_BITS-1:0]  port;     // Destination port.
        logic [ADDR_BITS-1:0]  addr;     // Sequence number.
        user_word_t            payload;
    } bft_packet_t;

endpackage

// ==== hdl/stream_fifo.sv ====
`timescale 1ns/1ps

module stream_fifo #(
    parameter int WIDTH      = 32,
    parameter int DEPTH_LOG2 = 4
) (
    input  logic             clk_400,
    input  logic             arst_n,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] wr_data,
    output logic             full,
    output logic [WIDTH-1:0] rd_data,
    output logic             rd_vld,
    input  logic             rd_ack
);

    localparam int DEPTH = 1 << DEPTH_LOG2;

    logic [WIDTH-1:0]      mem [DEPTH];
    logic [DEPTH_LOG2-1:0] wr_ptr;
    logic [DEPTH_LOG2-1:0] rd_ptr;
    logic [DEPTH_LOG2:0]   count;
    logic                  push;
    logic                  pop;

    assign full    = (count == (DEPTH_LOG2 + 1)'(DEPTH));
    assign rd_vld  = (count != '0);
    assign rd_data = mem[rd_ptr];       // Oldest entry.

    assign push = wr_en && !full;       // Write while full is dropped.
    assign pop  = rd_vld && rd_ack;

    always_ff @(posedge clk_400) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk_400 or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;    // Wraps at DEPTH.
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            unique case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== hdl/leaf_rx.sv ====
`timescale 1ns/1ps

module leaf_rx #(
    parameter int LEAF_ID    = 3,
    parameter int IN_PORT    = 1,
    parameter int DEPTH_LOG2 = 4
) (
    input  logic                 clk_400,
    input  logic                 arst_n,
    input  bft_pkg::bft_packet_t pkt_in,
    output bft_pkg::user_word_t  data,
    output logic                 vld,
    input  logic                 ack
);

    logic match;
    logic full;
    logic wr_en;

    // Accept only live packets for this leaf and port.
    assign match = pkt_in.vld
                && (pkt_in.leaf == bft_pkg::LEAF_BITS'(LEAF_ID))
                && (pkt_in.port == bft_pkg::PORT_BITS'(IN_PORT));

    // No back-pressure toward the tree, overflow is lost.
    assign wr_en = match && !full;

    stream_fifo #(
        .WIDTH      (bft_pkg::PAYLOAD_BITS),
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) in_fifo0 (
        .clk_400 (clk_400),
        .arst_n  (arst_n),
        .wr_en   (wr_en),
        .wr_data (pkt_in.payload),
        .full    (full),
        .rd_data (data),
        .rd_vld  (vld),
        .rd_ack  (ack)
    );

endmodule

// ==== hdl/leaf_tx.sv ====
`timescale 1ns/1ps

module leaf_tx #(
    parameter int DEST_LEAF_1 = 7,
    parameter int DEST_PORT_1 = 2,
    parameter int DEST_LEAF_2 = 9,
    parameter int DEST_PORT_2 = 5,
    parameter int DEPTH_LOG2  = 2
) (
    input  logic                 clk_400,
    input  logic                 arst_n,
    input  bft_pkg::user_word_t  data_1,
    input  logic                 vld_1,
    output logic                 ack_1,
    input  bft_pkg::user_word_t  data_2,
    input  logic                 vld_2,
    output logic                 ack_2,
    input  logic                 resend,
    output bft_pkg::bft_packet_t pkt_out
);

    logic                         full_1;
    logic                         full_2;
    bft_pkg::user_word_t          head_1;
    bft_pkg::user_word_t          head_2;
    logic                         head_vld_1;
    logic                         head_vld_2;
    logic                         pick_1;
    logic                         pick_2;
    logic                         prefer_2;    // Port 1 was served last.
    logic [bft_pkg::ADDR_BITS-1:0] seq_1;
    logic [bft_pkg::ADDR_BITS-1:0] seq_2;
    bft_pkg::bft_packet_t         pkt_next;

    // Ack only says there is room.
    assign ack_1 = !full_1;
    assign ack_2 = !full_2;

    stream_fifo #(
        .WIDTH      (bft_pkg::PAYLOAD_BITS),
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) out_fifo1 (
        .clk_400 (clk_400),
        .arst_n  (arst_n),
        .wr_en   (vld_1 && ack_1),
        .wr_data (data_1),
        .full    (full_1),
        .rd_data (head_1),
        .rd_vld  (head_vld_1),
        .rd_ack  (pick_1)
    );

    stream_fifo #(
        .WIDTH      (bft_pkg::PAYLOAD_BITS),
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) out_fifo2 (
        .clk_400 (clk_400),
        .arst_n  (arst_n),
        .wr_en   (vld_2 && ack_2),
        .wr_data (data_2),
        .full    (full_2),
        .rd_data (head_2),
        .rd_vld  (head_vld_2),
        .rd_ack  (pick_2)
    );

    // Round-robin pick, frozen during resend.
    always_comb begin
        pick_1 = 1'b0;
        pick_2 = 1'b0;
        if (!resend) begin
            if (prefer_2) begin
                pick_2 = head_vld_2;
                pick_1 = head_vld_1 && !head_vld_2;
            end else begin
                pick_1 = head_vld_1;
                pick_2 = head_vld_2 && !head_vld_1;
            end
        end
    end

    always_comb begin
        pkt_next = '0;     // Idle tree output is all zero.
        if (pick_1) begin
            pkt_next.vld     = 1'b1;
            pkt_next.leaf    = bft_pkg::LEAF_BITS'(DEST_LEAF_1);
            pkt_next.port    = bft_pkg::PORT_BITS'(DEST_PORT_1);
            pkt_next.addr    = seq_1;
            pkt_next.payload = head_1;
        end else if (pick_2) begin
            pkt_next.vld     = 1'b1;
            pkt_next.leaf    = bft_pkg::LEAF_BITS'(DEST_LEAF_2);
            pkt_next.port    = bft_pkg::PORT_BITS'(DEST_PORT_2);
            pkt_next.addr    = seq_2;
            pkt_next.payload = head_2;
        end
    end

    always_ff @(posedge clk_400 or negedge arst_n) begin
        if (!arst_n) begin
            pkt_out  <= '0;
            prefer_2 <= 1'b0;
            seq_1    <= '0;
            seq_2    <= '0;
        end else begin
            pkt_out <= pkt_next;
            if (pick_1) begin
                seq_1    <= seq_1 + 1'b1;  // Wraps at 128.
                prefer_2 <= 1'b1;
            end
            if (pick_2) begin
                seq_2    <= seq_2 + 1'b1;
                prefer_2 <= 1'b0;
            end
        end
    end

endmodule

// ==== hdl/leaf_interface.sv ====
`timescale 1ns/1ps

module leaf_interface #(
    parameter int LEAF_ID            = 3,
    parameter int IN_PORT            = 1,
    parameter int DEST_LEAF_1        = 7,
    parameter int DEST_PORT_1        = 2,
    parameter int DEST_LEAF_2        = 9,
    parameter int DEST_PORT_2        = 5,
    parameter int RX_FIFO_DEPTH_LOG2 = 4,
    parameter int TX_FIFO_DEPTH_LOG2 = 2
) (
    input  logic                 clk_400,
    input  logic                 arst_n,
    input  bft_pkg::bft_packet_t din_leaf_bft2interface,
    output bft_pkg::bft_packet_t dout_leaf_interface2bft,
    input  logic                 resend,
    input  logic                 ap_start,
    output logic                 user_rst_n,

    output bft_pkg::user_word_t  dout_leaf_interface2user_1,
    output logic                 vld_interface2user_1,
    input  logic                 ack_user2interface_1,

    input  bft_pkg::user_word_t  din_leaf_user2interface_1,
    input  logic                 vld_user2interface_1,
    output logic                 ack_interface2user_1,
    input  bft_pkg::user_word_t  din_leaf_user2interface_2,
    input  logic                 vld_user2interface_2,
    output logic                 ack_interface2user_2
);

    logic [1:0] start_sync;
    logic       start_seen;

    // ap_start comes from outside the clock domain.
    always_ff @(posedge clk_400 or negedge arst_n) begin
        if (!arst_n) begin
            start_sync <= '0;
            start_seen <= 1'b0;
        end else begin
            start_sync <= {start_sync[0], ap_start};
            start_seen <= start_seen || start_sync[1];  // Sticky until arst_n.
        end
    end

    assign user_rst_n = start_seen;

    leaf_rx #(
        .LEAF_ID    (LEAF_ID),
        .IN_PORT    (IN_PORT),
        .DEPTH_LOG2 (RX_FIFO_DEPTH_LOG2)
    ) leaf_rx0 (
        .clk_400 (clk_400),
        .arst_n  (arst_n),
        .pkt_in  (din_leaf_bft2interface),
        .data    (dout_leaf_interface2user_1),
        .vld     (vld_interface2user_1),
        .ack     (ack_user2interface_1)
    );

    leaf_tx #(
        .DEST_LEAF_1 (DEST_LEAF_1),
        .DEST_PORT_1 (DEST_PORT_1),
        .DEST_LEAF_2 (DEST_LEAF_2),
        .DEST_PORT_2 (DEST_PORT_2),
        .DEPTH_LOG2  (TX_FIFO_DEPTH_LOG2)
    ) leaf_tx0 (
        .clk_400 (clk_400),
        .arst_n  (arst_n),
        .data_1  (din_leaf_user2interface_1),
        .vld_1   (vld_user2interface_1),
        .ack_1   (ack_interface2user_1),
        .data_2  (din_leaf_user2interface_2),
        .vld_2   (vld_user2interface_2),
        .ack_2   (ack_interface2user_2),
        .resend  (resend),
        .pkt_out (dout_leaf_interface2bft)
    );

endmodule

// ==== hdl/user_kernel.sv ====
`timescale 1ns/1ps

module user_kernel (
    input  logic                clk_400,
    input  logic                user_rst_n,

    input  bft_pkg::user_word_t dout_leaf_interface2user_1,
    input  logic                vld_interface2user_1,
    output logic                ack_user2interface_1,

    output bft_pkg::user_word_t din_leaf_user2interface_1,
    output logic                vld_user2interface_1,
    input  logic                ack_interface2user_1,
    output bft_pkg::user_word_t din_leaf_user2interface_2,
    output logic                vld_user2interface_2,
    input  logic                ack_interface2user_2
);

    bft_pkg::user_word_t sum_q;
    bft_pkg::user_word_t sum_next;
    bft_pkg::user_word_t swapped;
    logic                take;

    // Take a word only out of reset and when both result registers are free.
    assign ack_user2interface_1 = user_rst_n
                               && !vld_user2interface_1 && !vld_user2interface_2;
    assign take = vld_interface2user_1 && ack_user2interface_1;

    assign sum_next = sum_q + dout_leaf_interface2user_1;
    assign swapped  = {dout_leaf_interface2user_1[7:0],
                       dout_leaf_interface2user_1[15:8],
                       dout_leaf_interface2user_1[23:16],
                       dout_leaf_interface2user_1[31:24]};

    always_ff @(posedge clk_400) begin
        if (take) begin
            din_leaf_user2interface_1 <= swapped;
            din_leaf_user2interface_2 <= sum_next;
        end
    end

    always_ff @(posedge clk_400 or negedge user_rst_n) begin
        if (!user_rst_n) begin
            sum_q                <= '0;
            vld_user2interface_1 <= 1'b0;
            vld_user2interface_2 <= 1'b0;
        end else if (take) begin
            sum_q                <= sum_next;
            vld_user2interface_1 <= 1'b1;
            vld_user2interface_2 <= 1'b1;
        end else begin
            // Each port drains on its own.
            if (ack_interface2user_1) begin
                vld_user2interface_1 <= 1'b0;
            end
            if (ack_interface2user_2) begin
                vld_user2interface_2 <= 1'b0;
            end
        end
    end

endmodule

// ==== hdl/leaf_i1o2.sv ====
`timescale 1ns/1ps

module leaf_i1o2 #(
    parameter int LEAF_ID            = 3,
    parameter int IN_PORT            = 1,
    parameter int DEST_LEAF_1        = 7,
    parameter int DEST_PORT_1        = 2,
    parameter int DEST_LEAF_2        = 9,
    parameter int DEST_PORT_2        = 5,
    parameter int RX_FIFO_DEPTH_LOG2 = 4,
    parameter int TX_FIFO_DEPTH_LOG2 = 2
) (
    input  logic                 clk_400,
    input  logic                 arst_n,
    input  bft_pkg::bft_packet_t din_leaf_bft2interface,
    output bft_pkg::bft_packet_t dout_leaf_interface2bft,
    input  logic                 resend,
    input  logic                 ap_start
);

    logic                user_rst_n;
    bft_pkg::user_word_t dout_leaf_interface2user_1;
    logic                vld_interface2user_1;
    logic                ack_user2interface_1;
    bft_pkg::user_word_t din_leaf_user2interface_1;
    bft_pkg::user_word_t din_leaf_user2interface_2;
    logic                vld_user2interface_1;
    logic                vld_user2interface_2;
    logic                ack_interface2user_1;
    logic                ack_interface2user_2;

    leaf_interface #(
        .LEAF_ID            (LEAF_ID),
        .IN_PORT            (IN_PORT),
        .DEST_LEAF_1        (DEST_LEAF_1),
        .DEST_PORT_1        (DEST_PORT_1),
        .DEST_LEAF_2        (DEST_LEAF_2),
        .DEST_PORT_2        (DEST_PORT_2),
        .RX_FIFO_DEPTH_LOG2 (RX_FIFO_DEPTH_LOG2),
        .TX_FIFO_DEPTH_LOG2 (TX_FIFO_DEPTH_LOG2)
    ) leaf_interface0 (
        .clk_400                    (clk_400),
        .arst_n                     (arst_n),
        .din_leaf_bft2interface     (din_leaf_bft2interface),
        .dout_leaf_interface2bft    (dout_leaf_interface2bft),
        .resend                     (resend),
        .ap_start                   (ap_start),
        .user_rst_n                 (user_rst_n),
        .dout_leaf_interface2user_1 (dout_leaf_interface2user_1),
        .vld_interface2user_1       (vld_interface2user_1),
        .ack_user2interface_1       (ack_user2interface_1),
        .din_leaf_user2interface_1  (din_leaf_user2interface_1),
        .vld_user2interface_1       (vld_user2interface_1),
        .ack_interface2user_1       (ack_interface2user_1),
        .din_leaf_user2interface_2  (din_leaf_user2interface_2),
        .vld_user2interface_2       (vld_user2interface_2),
        .ack_interface2user_2       (ack_interface2user_2)
    );

    user_kernel user_kernel0 (
        .clk_400                    (clk_400),
        .user_rst_n                 (user_rst_n),     // Held until ap_start.
        .dout_leaf_interface2user_1 (dout_leaf_interface2user_1),
        .vld_interface2user_1       (vld_interface2user_1),
        .ack_user2interface_1       (ack_user2interface_1),
        .din_leaf_user2interface_1  (din_leaf_user2interface_1),
        .vld_user2interface_1       (vld_user2interface_1),
        .ack_interface2user_1       (ack_interface2user_1),
        .din_leaf_user2interface_2  (din_leaf_user2interface_2),
        .vld_user2interface_2       (vld_user2interface_2),
        .ack_interface2user_2       (ack_interface2user_2)
    );

endmodule

// ==== test/tb_leaf.sv ====
`timescale 1ns/1ps

module tb_leaf;

    localparam int LEAF_ID        = 3;
    localparam int IN_PORT        = 1;
    localparam int DEST_LEAF_1    = 7;
    localparam int DEST_PORT_1    = 2;
    localparam int DEST_LEAF_2    = 9;
    localparam int DEST_PORT_2    = 5;
    localparam int WORDS          = 10 + 12 + 200;
    localparam int TIMEOUT_CYCLES = 40 * WORDS + 2000;

    typedef struct packed {
        bft_pkg::user_word_t p1;
        bft_pkg::user_word_t p2;
    } result_pair_t;

    logic                          clk_400 = 1'b0;
    logic                          arst_n;
    bft_pkg::bft_packet_t          din_leaf_bft2interface;
    bft_pkg::bft_packet_t          dout_leaf_interface2bft;
    logic                          resend;
    logic                          ap_start;

    bft_pkg::bft_packet_t          q1[$];
    bft_pkg::bft_packet_t          q2[$];
    bft_pkg::user_word_t           run_sum = '0;
    logic [bft_pkg::ADDR_BITS-1:0] seq_1 = '0;
    logic [bft_pkg::ADDR_BITS-1:0] seq_2 = '0;
    integer                        seed = 32'h59a24be7;
    int                            value_errors = 0;
    int                            other_errors = 0;
    int                            cycles = 0;
    logic                          resend_prev = 1'b0;

    always #4 clk_400 = ~clk_400;

    leaf_i1o2 #(
        .LEAF_ID     (LEAF_ID),
        .IN_PORT     (IN_PORT),
        .DEST_LEAF_1 (DEST_LEAF_1),
        .DEST_PORT_1 (DEST_PORT_1),
        .DEST_LEAF_2 (DEST_LEAF_2),
        .DEST_PORT_2 (DEST_PORT_2)
    ) dut0 (
        .clk_400                 (clk_400),
        .arst_n                  (arst_n),
        .din_leaf_bft2interface  (din_leaf_bft2interface),
        .dout_leaf_interface2bft (dout_leaf_interface2bft),
        .resend                  (resend),
        .ap_start                (ap_start)
    );

    // Port 1 gets the bytes reversed, port 2 the running sum.
    function automatic result_pair_t expected_payloads(bft_pkg::user_word_t w,
                                                       bft_pkg::user_word_t sum);
        result_pair_t r;
        for (int i = 0; i < 4; i++) begin
            r.p1[8*i +: 8] = w[8*(3-i) +: 8];
        end
        r.p2 = sum + w;
        return r;
    endfunction

    task automatic push_expected(bft_pkg::user_word_t w);
        result_pair_t         r;
        bft_pkg::bft_packet_t p;
        r = expected_payloads(w, run_sum);
        run_sum = r.p2;
        p.vld     = 1'b1;
        p.leaf    = bft_pkg::LEAF_BITS'(DEST_LEAF_1);
        p.port    = bft_pkg::PORT_BITS'(DEST_PORT_1);
        p.addr    = seq_1;
        p.payload = r.p1;
        q1.push_back(p);
        seq_1 = seq_1 + 1'b1;      // Wraps at 128.
        p.leaf    = bft_pkg::LEAF_BITS'(DEST_LEAF_2);
        p.port    = bft_pkg::PORT_BITS'(DEST_PORT_2);
        p.addr    = seq_2;
        p.payload = r.p2;
        q2.push_back(p);
        seq_2 = seq_2 + 1'b1;
    endtask

    task automatic drive_cycle(bft_pkg::bft_packet_t p);
        @(posedge clk_400);
        din_leaf_bft2interface <= p;
    endtask

    task automatic idle_cycles(int n);
        repeat (n) drive_cycle('0);
    endtask

    task automatic send_word(bft_pkg::user_word_t w);
        bft_pkg::bft_packet_t p;
        p.vld     = 1'b1;
        p.leaf    = bft_pkg::LEAF_BITS'(LEAF_ID);
        p.port    = bft_pkg::PORT_BITS'(IN_PORT);
        p.addr    = bft_pkg::ADDR_BITS'($random(seed));
        p.payload = w;
        drive_cycle(p);
        push_expected(w);
    endtask

    // Wrong leaf, wrong port, or vld clear.
    task automatic send_bad(int kind);
        bft_pkg::bft_packet_t p;
        p.vld     = 1'b1;
        p.leaf    = bft_pkg::LEAF_BITS'(LEAF_ID);
        p.port    = bft_pkg::PORT_BITS'(IN_PORT);
        p.addr    = '0;
        p.payload = $random(seed);
        case (kind)
            0:       p.leaf = bft_pkg::LEAF_BITS'(LEAF_ID + 1);
            1:       p.port = bft_pkg::PORT_BITS'(IN_PORT + 1);
            default: p.vld = 1'b0;
        endcase
        drive_cycle(p);
    endtask

    task automatic resend_window(int n);
        repeat (n) begin
            @(posedge clk_400);
            resend                 <= 1'b1;
            din_leaf_bft2interface <= '0;
        end
        @(posedge clk_400);
        resend <= 1'b0;
    endtask

    task automatic wait_drain();
        while (q1.size() != 0 || q2.size() != 0) begin
            @(posedge clk_400);
        end
    endtask

    task automatic check_packet(bft_pkg::bft_packet_t exp, bft_pkg::bft_packet_t act);
        if (act.leaf != exp.leaf) begin
            $display("[FAIL] dout_leaf_interface2bft.leaf expected %h actual %h",
                     exp.leaf, act.leaf);
            value_errors = value_errors + 1;
        end
        if (act.port != exp.port) begin
            $display("[FAIL] dout_leaf_interface2bft.port expected %h actual %h",
                     exp.port, act.port);
            value_errors = value_errors + 1;
        end
        if (act.addr != exp.addr) begin
            $display("[FAIL] dout_leaf_interface2bft.addr expected %h actual %h",
                     exp.addr, act.addr);
            value_errors = value_errors + 1;
        end
        if (act.payload != exp.payload) begin
            $display("[FAIL] dout_leaf_interface2bft.payload expected %h actual %h",
                     exp.payload, act.payload);
            value_errors = value_errors + 1;
        end
    endtask

    task automatic check_idle(bft_pkg::bft_packet_t act);
        if (act != '0) begin
            $display("[FAIL] dout_leaf_interface2bft expected %h actual %h",
                     bft_pkg::bft_packet_t'('0), act);
            value_errors = value_errors + 1;
        end
    endtask

    task automatic finish_run();
        if (q1.size() != 0 || q2.size() != 0) begin
            $display("Missing packets: %0d for port 1 and %0d for port 2 never arrived",
                     q1.size(), q2.size());
            other_errors = other_errors + 1;
        end
        $display("Errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    // Scoreboard, sampled at every rising edge.
    always @(posedge clk_400) begin
        cycles = cycles + 1;
        resend_prev <= resend;     // Used at the next edge.
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            other_errors = other_errors + 1;
            finish_run();
        end else if (arst_n) begin
            if (resend_prev || !dout_leaf_interface2bft.vld) begin
                check_idle(dout_leaf_interface2bft);
            end else if (!ap_start) begin
                $display("A packet left the leaf before ap_start was raised");
                other_errors = other_errors + 1;
            end else if (dout_leaf_interface2bft.leaf == bft_pkg::LEAF_BITS'(DEST_LEAF_1)
                      && dout_leaf_interface2bft.port == bft_pkg::PORT_BITS'(DEST_PORT_1)) begin
                if (q1.size() == 0) begin
                    $display("Port 1 sent a packet that was not expected");
                    other_errors = other_errors + 1;
                end else begin
                    check_packet(q1.pop_front(), dout_leaf_interface2bft);
                end
            end else if (dout_leaf_interface2bft.leaf == bft_pkg::LEAF_BITS'(DEST_LEAF_2)
                      && dout_leaf_interface2bft.port == bft_pkg::PORT_BITS'(DEST_PORT_2)) begin
                if (q2.size() == 0) begin
                    $display("Port 2 sent a packet that was not expected");
                    other_errors = other_errors + 1;
                end else begin
                    check_packet(q2.pop_front(), dout_leaf_interface2bft);
                end
            end else begin
                $display("A packet went to unknown leaf %0d port %0d",
                         dout_leaf_interface2bft.leaf, dout_leaf_interface2bft.port);
                other_errors = other_errors + 1;
            end
        end
    end

    initial begin
        int gap;
        arst_n                 = 1'b0;
        din_leaf_bft2interface = '0;
        resend                 = 1'b0;
        ap_start               = 1'b0;
        repeat (3) @(posedge clk_400);
        arst_n <= 1'b1;
        idle_cycles(20);
        for (int i = 0; i < 10; i++) begin
            send_word($random(seed));      // Held in the inbound FIFO.
        end
        idle_cycles(30);
        @(posedge clk_400);
        ap_start <= 1'b1;
        wait_drain();
        for (int i = 0; i < 12; i++) begin
            send_word($random(seed));
            send_bad(i % 3);
            idle_cycles(2);
        end
        wait_drain();
        for (int i = 0; i < 200; i++) begin
            send_word($random(seed));
            gap = 2 + int'($unsigned($random(seed)) % 4);
            idle_cycles(gap);
            if (($random(seed) & 7) == 0) begin
                resend_window(1 + int'($unsigned($random(seed)) % 12));
            end
        end
        wait_drain();
        idle_cycles(20);                   // Catches late duplicates.
        finish_run();
    end

endmodule

// ==== tb.f ====
hdl/bft_pkg.sv
hdl/stream_fifo.sv
hdl/leaf_rx.sv
hdl/leaf_tx.sv
hdl/leaf_interface.sv
hdl/user_kernel.sv
hdl/leaf_i1o2.sv
test/tb_leaf.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing --top-module tb_leaf -f tb.f -o tb_leaf
./obj_dir/tb_leaf > sim.log
cat sim.log
if grep -q "^Done: no errors$" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
